// ==== source/mmio_pkg.sv ====
package mmio_pkg;

    // data and address word of the processor bus
    typedef logic [15:0] word_t;

    // word index into the on-chip RAM
    typedef logic [11:0] ram_addr_t;

    // pixel coordinate on the 32 by 32 grid
    typedef logic [4:0] pix_coord_t;

    // data address map
    // everything up to RAM_LAST aliases into RAM by the low 12 bits
    localparam word_t RAM_LAST = 16'hF7FF;

    localparam word_t LED_FIRST = 16'hF800;
    localparam word_t LED_LAST = 16'hF809;

    // read returns 1 while the transmitter is idle
    localparam word_t UART_TX_READY = 16'hF80A;

    // write sends the low byte of the data word
    localparam word_t UART_TX_BYTE = 16'hF80B;

    // three writes in turn: x, y, colour
    localparam word_t VGA_WRITE = 16'hF80C;

    // RAM index of pixel (0,0), rows are 32 words apart
    localparam ram_addr_t FB_BASE = 12'hC00;

    localparam int LED_COUNT = 10;

    // clock cycles per serial bit
    localparam int UART_DIV = 8;

    localparam int RAM_WORDS = 4096;

endpackage

// ==== source/word_ram.sv ====
module word_ram (
    input  logic                clk,
    input  logic                rst,
    input  logic                wb_cyc,
    input  logic                wb_stb,
    input  logic                wb_we,
    input  mmio_pkg::ram_addr_t wb_adr,
    input  mmio_pkg::word_t     wb_dat_w,
    output logic                wb_ack,
    output mmio_pkg::word_t     wb_dat_r
);

    mmio_pkg::word_t mem [mmio_pkg::RAM_WORDS];

    logic access;

    // a strobe is served once; the cycle carrying the ack never starts another
    assign access = wb_cyc && wb_stb && !wb_ack;

    always_ff @(posedge clk) begin
        if (!rst) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= access;
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            if (wb_we) begin
                mem[wb_adr] <= wb_dat_w;
            end
            wb_dat_r <= mem[wb_adr];
        end
    end

endmodule

// ==== source/uart_tx.sv ====
module uart_tx (
    input  logic       clk,
    input  logic       rst,
    input  logic       tx_start,
    input  logic [7:0] tx_data,
    output logic       tx_ready,
    output logic       txd
);

    localparam int DIV_W = $clog2(mmio_pkg::UART_DIV);

    // bits after the start bit: eight data bits, then the stop bit
    localparam int FRAME_LAST = 9;

    logic [DIV_W-1:0] div_cnt;
    logic [3:0]       bit_cnt;
    logic [8:0]       shift;
    logic             bit_end;
    logic             last_bit;

    assign bit_end = !tx_ready && div_cnt == DIV_W'(mmio_pkg::UART_DIV - 1);
    assign last_bit = bit_cnt == 4'(FRAME_LAST);

    always_ff @(posedge clk) begin
        if (!rst) begin
            tx_ready <= 1'b1;
            txd <= 1'b1;
            div_cnt <= '0;
            bit_cnt <= '0;
        end else if (tx_start) begin
            // start bit goes out right away
            tx_ready <= 1'b0;
            txd <= 1'b0;
            div_cnt <= '0;
            bit_cnt <= '0;
        end else if (!tx_ready) begin
            if (bit_end) begin
                div_cnt <= '0;
                if (last_bit) begin
                    tx_ready <= 1'b1;
                end else begin
                    txd <= shift[0];
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

    // lsb first, stop bit sits above the data
    always_ff @(posedge clk) begin
        if (tx_start) begin
            shift <= {1'b1, tx_data};
        end else if (bit_end && !last_bit) begin
            shift <= {1'b1, shift[8:1]};
        end
    end

endmodule

// ==== source/mem_map.sv ====
module mem_map (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            req,
    input  mmio_pkg::word_t                 pc,
    input  mmio_pkg::word_t                 data_addr,
    input  mmio_pkg::word_t                 data_in,
    input  logic                            write_en,
    input  logic                            wb_ack,
    input  mmio_pkg::word_t                 wb_dat_r,
    input  logic                            tx_ready,
    output logic                            busy,
    output logic                            done,
    output mmio_pkg::word_t                 instr,
    output mmio_pkg::word_t                 read_data,
    output logic [mmio_pkg::LED_COUNT-1:0]  led,
    output logic                            wb_cyc,
    output logic                            wb_stb,
    output logic                            wb_we,
    output mmio_pkg::ram_addr_t             wb_adr,
    output mmio_pkg::word_t                 wb_dat_w,
    output logic                            tx_start,
    output logic [7:0]                      tx_data
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_INSTR,
        S_DATA,
        S_DONE
    } state_t;

    // which word the next write to the pixel port carries
    typedef enum logic [1:0] {
        PIX_X,
        PIX_Y,
        PIX_COLOUR
    } pix_phase_t;

    state_t               state;
    pix_phase_t           pix_phase;
    mmio_pkg::pix_coord_t pix_x;
    mmio_pkg::pix_coord_t pix_y;

    logic                is_ram;
    logic                is_led;
    logic                is_ready;
    logic                is_tx_byte;
    logic                is_vga;
    logic [3:0]          led_idx;
    mmio_pkg::ram_addr_t fb_index;
    logic                pix_commit;
    logic                data_to_ram;
    logic                instr_ack;
    logic                io_step;

    // address decode
    assign is_ram = data_addr <= mmio_pkg::RAM_LAST;
    assign is_led = data_addr >= mmio_pkg::LED_FIRST && data_addr <= mmio_pkg::LED_LAST;
    assign is_ready = data_addr == mmio_pkg::UART_TX_READY;
    assign is_tx_byte = data_addr == mmio_pkg::UART_TX_BYTE;
    assign is_vga = data_addr == mmio_pkg::VGA_WRITE;

    assign led_idx = 4'(data_addr - mmio_pkg::LED_FIRST);

    // y * 32 + x is just the two coordinates side by side
    assign fb_index = mmio_pkg::FB_BASE + mmio_pkg::ram_addr_t'({pix_y, pix_x});

    // the colour write is the only pixel access that reaches RAM
    assign pix_commit = write_en && is_vga && pix_phase == PIX_COLOUR;
    assign data_to_ram = is_ram || pix_commit;

    assign instr_ack = state == S_INSTR && wb_ack;

    // I/O work happens on the edge that brings in the instruction
    assign io_step = instr_ack && !data_to_ram;

    assign busy = state != S_IDLE;
    assign done = state == S_DONE;

    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= S_IDLE;
            wb_cyc <= 1'b0;
            wb_stb <= 1'b0;
            tx_start <= 1'b0;
            led <= '0;
            instr <= 16'hFFFF;
            read_data <= '0;
            pix_phase <= PIX_X;
        end else begin
            // dropped when the transmitter is still busy
            tx_start <= io_step && write_en && is_tx_byte && tx_ready;

            case (state)
                S_IDLE: begin
                    if (req) begin
                        state <= S_INSTR;
                        wb_cyc <= 1'b1;
                        wb_stb <= 1'b1;
                    end
                end
                S_INSTR: begin
                    if (wb_ack) begin
                        instr <= wb_dat_r;
                        if (data_to_ram) begin
                            // strobe stays up for the data access
                            state <= S_DATA;
                        end else begin
                            state <= S_DONE;
                            wb_cyc <= 1'b0;
                            wb_stb <= 1'b0;
                        end
                    end
                end
                S_DATA: begin
                    if (wb_ack) begin
                        state <= S_DONE;
                        wb_cyc <= 1'b0;
                        wb_stb <= 1'b0;
                        if (!wb_we) begin
                            read_data <= wb_dat_r;
                        end
                    end
                end
                S_DONE: begin
                    state <= S_IDLE;
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase

            if (io_step) begin
                if (write_en && is_led) begin
                    led[led_idx] <= data_in[0];
                end
                // only the ready flag reads back, other I/O reads give zero
                if (!write_en) begin
                    read_data <= is_ready ? mmio_pkg::word_t'(tx_ready) : '0;
                end
            end

            if (instr_ack && write_en && is_vga) begin
                case (pix_phase)
                    PIX_X: pix_phase <= PIX_Y;
                    PIX_Y: pix_phase <= PIX_COLOUR;
                    default: pix_phase <= PIX_X;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE && req) begin
            wb_we <= 1'b0;
            wb_adr <= pc[11:0];
        end else if (instr_ack) begin
            wb_we <= write_en;
            wb_adr <= pix_commit ? fb_index : data_addr[11:0];
            wb_dat_w <= data_in;
        end

        if (io_step && write_en && is_tx_byte) begin
            tx_data <= data_in[7:0];
        end

        if (instr_ack && write_en && is_vga) begin
            if (pix_phase == PIX_X) begin
                pix_x <= data_in[4:0];
            end
            if (pix_phase == PIX_Y) begin
                pix_y <= data_in[4:0];
            end
        end
    end

endmodule

// ==== source/mmio_top.sv ====
module mmio_top (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            req,
    input  mmio_pkg::word_t                 pc,
    input  mmio_pkg::word_t                 data_addr,
    input  mmio_pkg::word_t                 data_in,
    input  logic                            write_en,
    output logic                            busy,
    output logic                            done,
    output mmio_pkg::word_t                 instr,
    output mmio_pkg::word_t                 read_data,
    output logic [mmio_pkg::LED_COUNT-1:0]  led,
    output logic                            txd
);

    // RAM port
    logic                wb_cyc;
    logic                wb_stb;
    logic                wb_we;
    mmio_pkg::ram_addr_t wb_adr;
    mmio_pkg::word_t     wb_dat_w;
    logic                wb_ack;
    mmio_pkg::word_t     wb_dat_r;

    // transmitter handshake
    logic       tx_start;
    logic [7:0] tx_data;
    logic       tx_ready;

    mem_map u_mem_map (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .pc        (pc),
        .data_addr (data_addr),
        .data_in   (data_in),
        .write_en  (write_en),
        .wb_ack    (wb_ack),
        .wb_dat_r  (wb_dat_r),
        .tx_ready  (tx_ready),
        .busy      (busy),
        .done      (done),
        .instr     (instr),
        .read_data (read_data),
        .led       (led),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w),
        .tx_start  (tx_start),
        .tx_data   (tx_data)
    );

    word_ram u_word_ram (
        .clk      (clk),
        .rst      (rst),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_ack   (wb_ack),
        .wb_dat_r (wb_dat_r)
    );

    uart_tx u_uart_tx (
        .clk      (clk),
        .rst      (rst),
        .tx_start (tx_start),
        .tx_data  (tx_data),
        .tx_ready (tx_ready),
        .txd      (txd)
    );

endmodule

// ==== test/tb_mmio_top.sv ====
module tb_mmio_top;

    logic                           clk = 1'b0;
    logic                           rst;
    logic                           req;
    mmio_pkg::word_t                pc;
    mmio_pkg::word_t                data_addr;
    mmio_pkg::word_t                data_in;
    logic                           write_en;
    logic                           busy;
    logic                           done;
    mmio_pkg::word_t                instr;
    mmio_pkg::word_t                read_data;
    logic [mmio_pkg::LED_COUNT-1:0] led;
    logic                           txd;

    // reference model
    mmio_pkg::word_t                mem_m [mmio_pkg::RAM_WORDS];
    bit                             known [mmio_pkg::RAM_WORDS];
    logic [mmio_pkg::LED_COUNT-1:0] led_m;
    int                             pix_n;
    mmio_pkg::pix_coord_t           pix_x_m;
    mmio_pkg::pix_coord_t           pix_y_m;
    mmio_pkg::word_t                read_m;
    logic                           ready_m;
    logic [31:0]                    lfsr = 32'h3bbe_5624;
    int                             written [$];

    mmio_top uut (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .pc        (pc),
        .data_addr (data_addr),
        .data_in   (data_in),
        .write_en  (write_en),
        .busy      (busy),
        .done      (done),
        .instr     (instr),
        .read_data (read_data),
        .led       (led),
        .txd       (txd)
    );

    always #4 clk = ~clk;

    // taps 32, 22, 2, 1
    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r = {r[14:0], fb};
        end
        return r;
    endfunction

    // pc aliased onto a word that was already written
    function automatic mmio_pkg::word_t pick_pc();
        logic [11:0] idx;
        idx = '0;
        if (written.size() > 0) begin
            idx = 12'(written[rand_bits(8) % written.size()]);
        end
        return {4'(rand_bits(4)), idx};
    endfunction

    task automatic stop_run(input string why);
        $display("tests failed");
        $fatal(1, "%s", why);
    endtask

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
            stop_run("a checked value did not match");
        end
    endtask

    task automatic run_access(input mmio_pkg::word_t pc_v, input mmio_pkg::word_t addr,
                              input mmio_pkg::word_t din, input logic we, input bit poke);
        mmio_pkg::word_t     exp_instr;
        bit                  instr_known;
        int                  n;
        mmio_pkg::ram_addr_t idx;
        // the fetch sees RAM before this request's own write
        instr_known = known[pc_v[11:0]];
        exp_instr = mem_m[pc_v[11:0]];
        if (addr <= mmio_pkg::RAM_LAST) begin
            if (we) begin
                mem_m[addr[11:0]] = din;
                known[addr[11:0]] = 1'b1;
            end else begin
                read_m = mem_m[addr[11:0]];
            end
        end else if (we && addr >= mmio_pkg::LED_FIRST && addr <= mmio_pkg::LED_LAST) begin
            led_m[addr - mmio_pkg::LED_FIRST] = din[0];
        end else if (we && addr == mmio_pkg::VGA_WRITE) begin
            if (pix_n == 0) begin
                pix_x_m = din[4:0];
            end else if (pix_n == 1) begin
                pix_y_m = din[4:0];
            end else begin
                idx = mmio_pkg::FB_BASE + 32 * pix_y_m + pix_x_m;
                mem_m[idx] = din;
                known[idx] = 1'b1;
            end
            pix_n = (pix_n + 1) % 3;
        end else if (!we) begin
            read_m = (addr == mmio_pkg::UART_TX_READY) ? mmio_pkg::word_t'(ready_m) : '0;
        end

        @(negedge clk);
        pc = pc_v;
        data_addr = addr;
        data_in = din;
        write_en = we;
        req = 1'b1;
        for (n = 0; n < 40 && !done; n++) begin
            @(negedge clk);
            // second pulse lands while the sequencer is busy
            req = poke && n == 1;
            if (req) begin
                check_value("busy", busy, 16'h1);
            end
        end
        if (!done) begin
            stop_run("done never came after a request");
        end
        if (instr_known) begin
            check_value("instr", instr, exp_instr);
        end
        check_value("read_data", read_data, read_m);
        check_value("led", led, led_m);
    endtask

    // samples each bit in its middle
    task automatic decode_byte(output logic [7:0] byte_v);
        int n;
        n = 0;
        while (txd !== 1'b0) begin
            @(negedge clk);
            n++;
            if (n > 40) begin
                stop_run("the start bit never appeared on txd");
            end
        end
        repeat (mmio_pkg::UART_DIV / 2 - 1) @(negedge clk);
        check_value("txd start bit", txd, 16'h0);
        for (int i = 0; i < 8; i++) begin
            repeat (mmio_pkg::UART_DIV) @(negedge clk);
            byte_v[i] = txd;
        end
        repeat (mmio_pkg::UART_DIV) @(negedge clk);
        check_value("txd stop bit", txd, 16'h1);
    endtask

    initial begin
        mmio_pkg::word_t addr;
        mmio_pkg::word_t xw;
        mmio_pkg::word_t yw;
        mmio_pkg::word_t colour;
        logic [7:0]      tx_byte;
        logic [7:0]      got_byte;
        rst = 1'b0;
        req = 1'b0;
        pc = '0;
        data_addr = '0;
        data_in = '0;
        write_en = 1'b0;
        led_m = '0;
        pix_n = 0;
        read_m = '0;
        ready_m = 1'b1;
        repeat (8) @(negedge clk);
        rst = 1'b1;
        check_value("led", led, 16'h0);
        check_value("txd", txd, 16'h1);
        check_value("busy", busy, 16'h0);
        check_value("instr", instr, 16'hFFFF);

        for (int i = 0; i < 40; i++) begin
            addr = rand_bits(16);
            if (addr > mmio_pkg::RAM_LAST) begin
                addr[15] = 1'b0;
            end
            run_access(pick_pc(), addr, rand_bits(16), 1'b1, 1'b0);
            written.push_back(addr[11:0]);
        end
        // read back through a random alias of each word
        foreach (written[i]) begin
            addr = {1'b0, 3'(rand_bits(3)), 12'(written[i])};
            run_access(pick_pc(), addr, 16'h0, 1'b0, 1'b0);
        end

        for (int i = 0; i < 30; i++) begin
            addr = mmio_pkg::LED_FIRST + rand_bits(4) % mmio_pkg::LED_COUNT;
            run_access(pick_pc(), addr, rand_bits(1), 1'b1, 1'b0);
        end

        tx_byte = 8'(rand_bits(8));
        run_access(pick_pc(), mmio_pkg::UART_TX_BYTE, {8'h00, tx_byte}, 1'b1, 1'b0);
        ready_m = 1'b0;
        fork
            decode_byte(got_byte);
            run_access(pick_pc(), mmio_pkg::UART_TX_READY, 16'h0, 1'b0, 1'b0);
        join
        check_value("uart byte", got_byte, tx_byte);
        // decoding stops mid stop bit and ready returns 80 cycles after the start
        repeat (mmio_pkg::UART_DIV) @(negedge clk);
        ready_m = 1'b1;
        run_access(pick_pc(), mmio_pkg::UART_TX_READY, 16'h0, 1'b0, 1'b0);

        for (int i = 0; i < 6; i++) begin
            xw = rand_bits(16);
            yw = rand_bits(16);
            colour = rand_bits(16);
            run_access(pick_pc(), mmio_pkg::VGA_WRITE, xw, 1'b1, 1'b0);
            run_access(pick_pc(), mmio_pkg::VGA_WRITE, 16'h0, 1'b0, 1'b0);
            run_access(pick_pc(), mmio_pkg::VGA_WRITE, yw, 1'b1, 1'b0);
            run_access(pick_pc(), mmio_pkg::VGA_WRITE, colour, 1'b1, 1'b0);
            addr = 16'(mmio_pkg::FB_BASE) + 16'(yw[4:0]) * 16'd32 + 16'(xw[4:0]);
            run_access(pick_pc(), addr, 16'h0, 1'b0, 1'b0);
        end

        run_access(pick_pc(), 16'hF8FF, 16'h0, 1'b0, 1'b1);
        repeat (6) begin
            @(negedge clk);
            check_value("done", done, 16'h0);
        end

        $display("all tests passed");
        $finish;
    end

endmodule

// ==== mmio_top.f ====
source/mmio_pkg.sv
source/word_ram.sv
source/uart_tx.sv
source/mem_map.sv
source/mmio_top.sv
test/tb_mmio_top.sv

// ==== Bender.yml ====
package:
  name: mmio_top

sources:
  - source/mmio_pkg.sv
  - source/word_ram.sv
  - source/uart_tx.sv
  - source/mem_map.sv
  - source/mmio_top.sv
  - target: test
    files:
      - test/tb_mmio_top.sv
